//--- compile.f
+incdir+source
source/mem_pkg.sv
source/unified_memory.sv
source/fetch_unit.sv
source/data_port_ctrl.sv
source/mem_subsystem_top.sv
sim/mem_subsystem_properties.sv
sim/mem_subsystem_tb.sv

//--- sim/mem_subsystem_tb.sv
`timescale 1ns/10ps

module mem_subsystem_tb
	import mem_pkg::*;
;

	localparam int HALF_PERIOD = 10;
	localparam int CLK_PERIOD = 2 * HALF_PERIOD;
	localparam int RESET_CYCLES = 10;
	localparam int WAIT_LIMIT = 20;

	// Cycle budgets of reset and each test
	localparam int BUDGET = RESET_CYCLES + 50 + 40 + 15 + 25 + 20;
	localparam int WATCHDOG_CYCLES = 2 * BUDGET;

	logic              clk = 1'b0;
	logic              reset_n;
	logic              fetch_enable;
	logic              redirect;
	logic [WORD_W-1:0] redirect_pc;
	logic [WORD_W-1:0] fetch_instr;
	logic [WORD_W-1:0] fetch_pc;
	logic              fetch_valid;
	logic              data_read;
	logic              data_write;
	logic [WORD_W-1:0] data_addr;
	logic [WORD_W-1:0] data_wdata;
	logic [WORD_W-1:0] data_rdata;
	logic              data_rvalid;
	logic              data_busy;

	// Boot image table and the running copy of memory
	logic [WORD_W-1:0] mem [0:MEM_WORDS-1];
	logic [WORD_W-1:0] shadow [0:MEM_WORDS-1];

	int cycle = 0;
	int release_edge;
	int checks = 0;
	int test_errors = 0;
	int total_errors = 0;
	int tests_run = 0;

	mem_subsystem_top dut (.*);

	always #(HALF_PERIOD) clk = ~clk;

	always @(posedge clk) begin
		cycle <= cycle + 1;
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Watchdog expired after %0d cycles, run stopped", WATCHDOG_CYCLES);
		$display("RESULT: FAIL");
		$finish;
	end

	// ******************************************************************
	// Helpers
	// ******************************************************************

	task automatic step_clk();
		@(posedge clk);
		#2;
	endtask

	task automatic load_boot_table();
		for (int i = 0; i < MEM_WORDS; i++) begin
			mem[i] <= '0;
		end
		`include "boot_image.svh"
	endtask

	task automatic check_value(input string test, input logic [31:0] exp, act);
		checks++;
		assert (act === exp) else begin
			$display("ERROR: %s: expected %0h, actual %0h", test, exp, act);
			test_errors++;
		end
	endtask

	task automatic check_true(input string test, input bit cond, input string what);
		checks++;
		assert (cond) else begin
			$display("%s: %s", test, what);
			test_errors++;
		end
	endtask

	task automatic wait_fetch(input string test);
		int n;
		n = 0;
		do begin
			step_clk();
			n++;
		end while (fetch_valid !== 1'b1 && n < WAIT_LIMIT);
		check_true(test, fetch_valid === 1'b1, "fetch_valid never arrived");
	endtask

	task automatic wait_rvalid(input string test);
		int n;
		n = 0;
		do begin
			step_clk();
			n++;
		end while (data_rvalid !== 1'b1 && n < WAIT_LIMIT);
		check_true(test, data_rvalid === 1'b1, "data_rvalid never arrived");
	endtask

	task automatic wait_idle(input string test);
		int n;
		n = 0;
		while (data_busy !== 1'b0 && n < WAIT_LIMIT) begin
			step_clk();
			n++;
		end
		check_true(test, data_busy === 1'b0, "data port stayed busy");
	endtask

	task automatic write_word(input string test, input logic [WORD_W-1:0] addr, value);
		data_addr = addr;
		data_wdata = value;
		data_write = 1'b1;
		step_clk();
		data_write = 1'b0;
		shadow[addr[INDEX_W-1:0]] = value;
		wait_idle(test);
	endtask

	// Checks read latency and data against the shadow
	task automatic read_and_compare(input string test, input logic [WORD_W-1:0] addr);
		int start;
		data_addr = addr;
		data_read = 1'b1;
		step_clk();
		start = cycle;
		data_read = 1'b0;
		wait_rvalid(test);
		check_value(test, 2, cycle - start);
		check_value(test, shadow[addr[INDEX_W-1:0]], data_rdata);
	endtask

	task automatic redirect_to(input logic [WORD_W-1:0] target, output int edge_no);
		redirect = 1'b1;
		redirect_pc = target;
		step_clk();
		edge_no = cycle;
		redirect = 1'b0;
	endtask

	task automatic end_test(input string test);
		total_errors += test_errors;
		tests_run++;
		$display("Test %s finished with %0d errors", test, test_errors);
		test_errors = 0;
	endtask

	// ******************************************************************
	// Tests
	// ******************************************************************

	task automatic fetch_sequence();
		int expect_edge;
		int k;
		expect_edge = release_edge + 2 + MEM_STALL_COUNT;
		for (k = 0; k < 8; k++) begin
			wait_fetch("fetch_sequence");
			check_value("fetch_sequence", expect_edge, cycle);
			check_value("fetch_sequence", RESET_PC + k, fetch_pc);
			check_value("fetch_sequence", mem[RESET_PC + k], fetch_instr);
			expect_edge += MEM_STALL_COUNT + 1;
		end
		end_test("fetch_sequence");
	endtask

	task automatic write_read_back();
		logic [WORD_W-1:0] addr;
		int k;
		for (k = 0; k < 6; k++) begin
			// Upper half is free of boot code
			addr = 16'h0080 | WORD_W'($urandom % 128);
			write_word("write_read_back", addr, WORD_W'($urandom));
			read_and_compare("write_read_back", addr);
		end
		end_test("write_read_back");
	endtask

	task automatic busy_reject();
		logic [WORD_W-1:0] addr_a;
		logic [WORD_W-1:0] addr_b;
		logic [WORD_W-1:0] value;
		addr_a = 16'h0080 | WORD_W'($urandom % 128);
		addr_b = addr_a ^ 16'h0001;
		value = WORD_W'($urandom);
		data_addr = addr_a;
		data_wdata = value;
		data_write = 1'b1;
		step_clk();
		check_true("busy_reject", data_busy === 1'b1, "data_busy low during a write");
		// Second write lands while busy
		data_addr = addr_b;
		data_wdata = ~shadow[addr_b[INDEX_W-1:0]];
		step_clk();
		data_write = 1'b0;
		shadow[addr_a[INDEX_W-1:0]] = value;
		check_true("busy_reject", data_busy === 1'b0, "strobe seen while busy started an access");
		read_and_compare("busy_reject", addr_a);
		read_and_compare("busy_reject", addr_b);
		end_test("busy_reject");
	endtask

	task automatic redirect_fetch();
		logic [WORD_W-1:0] target;
		int r_edge;
		wait_fetch("redirect_fetch");
		target = (fetch_pc + 16'h0013) & 16'h003f;
		step_clk();
		step_clk();
		redirect_to(target, r_edge);
		wait_fetch("redirect_fetch");
		check_value("redirect_fetch", r_edge + MEM_STALL_COUNT, cycle);
		check_value("redirect_fetch", target, fetch_pc);
		check_value("redirect_fetch", shadow[target[INDEX_W-1:0]], fetch_instr);
		wait_fetch("redirect_fetch");
		check_value("redirect_fetch", r_edge + 2 * MEM_STALL_COUNT + 1, cycle);
		check_value("redirect_fetch", target + 1'b1, fetch_pc);
		end_test("redirect_fetch");
	endtask

	task automatic code_update();
		int r_edge;
		write_word("code_update", 16'h0060, WORD_W'($urandom) | 16'h8000);
		write_word("code_update", 16'h0061, WORD_W'($urandom) | 16'h8000);
		redirect_to(16'h0060, r_edge);
		wait_fetch("code_update");
		check_value("code_update", 16'h0060, fetch_pc);
		check_value("code_update", shadow[8'h60], fetch_instr);
		wait_fetch("code_update");
		check_value("code_update", 16'h0061, fetch_pc);
		check_value("code_update", shadow[8'h61], fetch_instr);
		end_test("code_update");
	endtask

	initial begin
		void'($urandom(85514));
		reset_n = 1'b0;
		fetch_enable = 1'b1;
		redirect = 1'b0;
		redirect_pc = '0;
		data_read = 1'b0;
		data_write = 1'b0;
		data_addr = '0;
		data_wdata = '0;
		load_boot_table();
		repeat (RESET_CYCLES) step_clk();
		shadow = mem;
		reset_n = 1'b1;
		release_edge = cycle;

		fetch_sequence();
		write_read_back();
		busy_reject();
		redirect_fetch();
		code_update();

		$display("Tests run: %0d, checks: %0d, errors: %0d", tests_run, checks, total_errors);
		if (total_errors == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

//--- sim/mem_subsystem_properties.sv
`timescale 1ns/10ps

module mem_subsystem_properties
	import mem_pkg::*;
(
	input logic              clk,
	input logic              reset_n,
	input logic              inst_ready,
	input logic [WORD_W-1:0] data1,
	input logic              read_m2,
	input logic              write_m2
);

	// Word return is a one-cycle pulse
	inst_ready_pulse: assert property (
		@(posedge clk) disable iff (!reset_n) inst_ready |=> !inst_ready
	) else $error("inst_ready held high for more than one cycle");

	// Instruction word only moves with a return
	data1_held: assert property (
		@(posedge clk) disable iff (!reset_n) $changed(data1) |-> inst_ready
	) else $error("data1 changed without inst_ready");

	// One bus driver at a time
	data_bus_owner: assert property (
		@(posedge clk) disable iff (!reset_n) !(read_m2 && write_m2)
	) else $error("read_m2 and write_m2 high together");

endmodule

bind unified_memory mem_subsystem_properties u_props (
	.clk       (clk),
	.reset_n   (reset_n),
	.inst_ready(inst_ready),
	.data1     (data1),
	.read_m2   (read_m2),
	.write_m2  (write_m2)
);

//--- source/mem_subsystem_top.sv
`timescale 1ns/10ps

module mem_subsystem_top
	import mem_pkg::*;
(
	input  logic              clk,
	input  logic              reset_n,

	// Fetch side
	input  logic              fetch_enable,
	input  logic              redirect,
	input  logic [WORD_W-1:0] redirect_pc,
	output logic [WORD_W-1:0] fetch_instr,
	output logic [WORD_W-1:0] fetch_pc,
	output logic              fetch_valid,

	// Data side
	input  logic              data_read,
	input  logic              data_write,
	input  logic [WORD_W-1:0] data_addr,
	input  logic [WORD_W-1:0] data_wdata,
	output logic [WORD_W-1:0] data_rdata,
	output logic              data_rvalid,
	output logic              data_busy
);

	logic              read_m1;
	logic [WORD_W-1:0] address1;
	logic [WORD_W-1:0] data1;
	logic              inst_ready;

	logic              read_m2;
	logic              write_m2;
	logic [WORD_W-1:0] address2;

	// Shared data bus driven by one side at a time
	wire  [WORD_W-1:0] data2;

	fetch_unit u_fetch (
		.clk         (clk),
		.reset_n     (reset_n),
		.fetch_enable(fetch_enable),
		.redirect    (redirect),
		.redirect_pc (redirect_pc),
		.data1       (data1),
		.inst_ready  (inst_ready),
		.read_m1     (read_m1),
		.address1    (address1),
		.fetch_instr (fetch_instr),
		.fetch_pc    (fetch_pc),
		.fetch_valid (fetch_valid)
	);

	data_port_ctrl u_dport (
		.clk        (clk),
		.reset_n    (reset_n),
		.data_read  (data_read),
		.data_write (data_write),
		.data_addr  (data_addr),
		.data_wdata (data_wdata),
		.data_rdata (data_rdata),
		.data_rvalid(data_rvalid),
		.data_busy  (data_busy),
		.read_m2    (read_m2),
		.write_m2   (write_m2),
		.address2   (address2),
		.data2      (data2)
	);

	unified_memory u_mem (
		.clk       (clk),
		.reset_n   (reset_n),
		.read_m1   (read_m1),
		.address1  (address1),
		.data1     (data1),
		.inst_ready(inst_ready),
		.read_m2   (read_m2),
		.write_m2  (write_m2),
		.address2  (address2),
		.data2     (data2)
	);

endmodule

//--- source/data_port_ctrl.sv
`timescale 1ns/10ps

module data_port_ctrl
	import mem_pkg::*;
(
	input  logic              clk,
	input  logic              reset_n,

	// Strobe side
	input  logic              data_read,
	input  logic              data_write,
	input  logic [WORD_W-1:0] data_addr,
	input  logic [WORD_W-1:0] data_wdata,
	output logic [WORD_W-1:0] data_rdata,
	output logic              data_rvalid,
	output logic              data_busy,

	// Memory data port
	output logic              read_m2,
	output logic              write_m2,
	output logic [WORD_W-1:0] address2,
	inout  wire  [WORD_W-1:0] data2
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_WRITE,
		ST_RD_ISSUE,
		ST_RD_HOLD
	} state_t;

	state_t            state;
	logic [WORD_W-1:0] addr_q;
	logic [WORD_W-1:0] wdata_q;
	logic              accept;

	// Strobes only count while idle
	assign accept = (state == ST_IDLE) && (data_read || data_write);

	// ******************************************************************
	// Access FSM
	// ******************************************************************

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			state <= ST_IDLE;
		end else begin
			case (state)
				ST_IDLE: begin
					// Write wins when both strobes come together
					if (data_write) begin
						state <= ST_WRITE;
					end else if (data_read) begin
						state <= ST_RD_ISSUE;
					end
				end
				ST_WRITE:    state <= ST_IDLE;
				ST_RD_ISSUE: state <= ST_RD_HOLD;
				ST_RD_HOLD:  state <= ST_IDLE;
				default:     state <= ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			addr_q <= data_addr;
			wdata_q <= data_wdata;
		end
	end

	assign address2 = addr_q;
	assign write_m2 = (state == ST_WRITE);
	assign read_m2 = (state == ST_RD_ISSUE) || (state == ST_RD_HOLD);
	assign data_busy = (state != ST_IDLE);
	assign data2 = write_m2 ? wdata_q : 'z;

	// ******************************************************************
	// Read capture
	// ******************************************************************

	// Memory word is on the bus in the hold cycle
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			data_rvalid <= 1'b0;
		end else begin
			data_rvalid <= (state == ST_RD_HOLD);
		end
	end

	always_ff @(posedge clk) begin
		if (state == ST_RD_HOLD) begin
			data_rdata <= data2;
		end
	end

endmodule

//--- source/fetch_unit.sv
`timescale 1ns/10ps

module fetch_unit
	import mem_pkg::*;
(
	input  logic              clk,
	input  logic              reset_n,

	// Control from the core
	input  logic              fetch_enable,
	input  logic              redirect,
	input  logic [WORD_W-1:0] redirect_pc,

	// Instruction port of the memory
	input  logic [WORD_W-1:0] data1,
	input  logic              inst_ready,
	output logic              read_m1,
	output logic [WORD_W-1:0] address1,

	// Fetched instruction
	output logic [WORD_W-1:0] fetch_instr,
	output logic [WORD_W-1:0] fetch_pc,
	output logic              fetch_valid
);

	logic [WORD_W-1:0] pc;
	logic              req_active;
	logic              take_word;

	// A word arriving with a redirect is dropped
	assign take_word = inst_ready && !redirect;

	// ******************************************************************
	// Request side
	// ******************************************************************

	// Redirect target goes to the memory on the same edge
	assign address1 = redirect ? redirect_pc : pc;

	// Low in the cycle the word is taken, unless a redirect restarts the wait
	assign read_m1 = req_active && (redirect || !inst_ready);

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			req_active <= 1'b0;
		end else begin
			req_active <= fetch_enable;
		end
	end

	// ******************************************************************
	// Program counter
	// ******************************************************************

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			pc <= RESET_PC;
		end else if (redirect) begin
			pc <= redirect_pc;
		end else if (inst_ready) begin
			pc <= pc + 1'b1;
		end
	end

	// ******************************************************************
	// Instruction output register
	// ******************************************************************

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			fetch_valid <= 1'b0;
		end else begin
			fetch_valid <= take_word;
		end
	end

	// Word and its pc travel together
	always_ff @(posedge clk) begin
		if (take_word) begin
			fetch_instr <= data1;
			fetch_pc <= pc;
		end
	end

endmodule

//--- source/unified_memory.sv
`timescale 1ns/10ps

module unified_memory
	import mem_pkg::*;
(
	input  logic              clk,
	input  logic              reset_n,

	// Instruction port
	input  logic              read_m1,
	input  logic [WORD_W-1:0] address1,
	output logic [WORD_W-1:0] data1,
	output logic              inst_ready,

	// Data port
	input  logic              read_m2,
	input  logic              write_m2,
	input  logic [WORD_W-1:0] address2,
	inout  wire  [WORD_W-1:0] data2
);

	logic [WORD_W-1:0] mem [0:MEM_WORDS-1];

	logic [INDEX_W-1:0]     index1;
	logic [INDEX_W-1:0]     index2;
	logic [WORD_W-1:0]      rd_data2;

	logic [STALL_CNT_W-1:0] stall_cnt;
	logic [STALL_CNT_W-1:0] cur_cnt;
	logic [WORD_W-1:0]      req_addr;
	logic                   same_req;
	logic                   fire;
	logic                   forward;

	assign index1 = address1[INDEX_W-1:0];
	assign index2 = address2[INDEX_W-1:0];

	// ******************************************************************
	// Instruction port stall counter
	// ******************************************************************

	// A request continues only while the address is unchanged
	assign same_req = (address1 == req_addr);
	assign cur_cnt = same_req ? stall_cnt : '0;
	assign fire = read_m1 && (cur_cnt == STALL_LAST);

	// Same-edge data write to the fetched word
	assign forward = write_m2 && (index2 == index1);

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			stall_cnt <= '0;
			inst_ready <= 1'b0;
		end else begin
			inst_ready <= fire;
			if (!read_m1 || fire) begin
				stall_cnt <= '0;
			end else begin
				stall_cnt <= cur_cnt + 1'b1;
			end
		end
	end

	// Address of the request being counted
	always_ff @(posedge clk) begin
		if (read_m1) begin
			req_addr <= address1;
		end
	end

	// data1 holds its word between returns
	always_ff @(posedge clk) begin
		if (fire) begin
			data1 <= forward ? data2 : mem[index1];
		end
	end

	// ******************************************************************
	// Word array
	// ******************************************************************

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			// Unused words come up as zero
			for (int i = 0; i < MEM_WORDS; i++) begin
				mem[i] <= '0;
			end
			`include "boot_image.svh"
		end else if (write_m2) begin
			mem[index2] <= data2;
		end
	end

	// ******************************************************************
	// Data port read
	// ******************************************************************

	always_ff @(posedge clk) begin
		if (read_m2) begin
			rd_data2 <= mem[index2];
		end
	end

	// Bus is ours only while read_m2 holds
	assign data2 = read_m2 ? rd_data2 : 'z;

endmodule

//--- source/mem_pkg.sv
package mem_pkg;

	// ******************************************************************
	// Memory geometry
	// ******************************************************************

	// Data and address word of the processor
	localparam int WORD_W = 16;

	// Only the low index bits select a word
	localparam int MEM_WORDS = 256;
	localparam int INDEX_W = 8;

	// ******************************************************************
	// Instruction port latency
	// ******************************************************************

	// Cycles an instruction address is held before its word returns
	localparam int MEM_STALL_COUNT = 4;
	localparam int STALL_CNT_W = 3;

	// Count value at the edge where the word is returned
	localparam logic [STALL_CNT_W-1:0] STALL_LAST = STALL_CNT_W'(MEM_STALL_COUNT - 1);

	// ******************************************************************
	// Fetch
	// ******************************************************************

	// First instruction address after reset
	localparam logic [WORD_W-1:0] RESET_PC = 16'h0000;

endpackage

//--- source/boot_image.svh
// ********************************************************************
// Boot program loaded into mem at reset
// ********************************************************************

// Register setup
mem[8'h00] <= 16'h6000;
mem[8'h01] <= 16'h6101;
mem[8'h02] <= 16'h4205;
mem[8'h03] <= 16'hf01c;
mem[8'h04] <= 16'h5201;
mem[8'h05] <= 16'hf41c;
mem[8'h06] <= 16'h6310;
mem[8'h07] <= 16'h4340;
mem[8'h08] <= 16'hf81c;
mem[8'h09] <= 16'h7301;
mem[8'h0a] <= 16'h8302;
mem[8'h0b] <= 16'hf01d;

// Counting loop
mem[8'h0c] <= 16'h9020;
mem[8'h0d] <= 16'h4401;
mem[8'h0e] <= 16'h5401;
mem[8'h0f] <= 16'hf41c;
mem[8'h10] <= 16'ha01a;
mem[8'h11] <= 16'h6500;
mem[8'h12] <= 16'h45ff;
mem[8'h13] <= 16'hf81c;
mem[8'h14] <= 16'h2402;
mem[8'h15] <= 16'hf01d;
mem[8'h16] <= 16'h3401;
mem[8'h17] <= 16'hf41c;
mem[8'h18] <= 16'h7c03;
mem[8'h19] <= 16'h8c04;
mem[8'h1a] <= 16'h4e02;
mem[8'h1b] <= 16'hf01c;

// Branch checks
mem[8'h1c] <= 16'hb101;
mem[8'h1d] <= 16'h0601;
mem[8'h1e] <= 16'h1601;
mem[8'h1f] <= 16'hf41d;
mem[8'h20] <= 16'h1b01;
mem[8'h21] <= 16'h2001;
mem[8'h22] <= 16'hf01c;
mem[8'h23] <= 16'h2801;
mem[8'h24] <= 16'h3001;
mem[8'h25] <= 16'h3801;
mem[8'h26] <= 16'hf41c;
mem[8'h27] <= 16'h9029;
mem[8'h28] <= 16'hf01d;

// ALU checks and halt
mem[8'h29] <= 16'hf2c0;
mem[8'h2a] <= 16'hf6c1;
mem[8'h2b] <= 16'hf1c2;
mem[8'h2c] <= 16'hfc1c;
mem[8'h2d] <= 16'hf4c3;
mem[8'h2e] <= 16'hf8c4;
mem[8'h2f] <= 16'hf0c5;
mem[8'h30] <= 16'hfc1c;
mem[8'h31] <= 16'h7dff;
mem[8'h32] <= 16'h8cff;
mem[8'h33] <= 16'h44ff;
mem[8'h34] <= 16'hf100;
mem[8'h35] <= 16'h4ffe;
mem[8'h36] <= 16'hf819;
mem[8'h37] <= 16'hf01d;
